//--- common/fetch_pkg.sv
package fetch_pkg;

  localparam int max_depth = 6;  // Widest buffer index the structs can carry.

  // **************************************************
  // Memory handshake, shared by core side and imem side.
  // **************************************************

  typedef struct packed {
    logic        valid;
    logic        fence;
    logic        instr;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
  } mem_req_t;

  typedef struct packed {
    logic        ready;
    logic [31:0] rdata;
  } mem_rsp_t;

  // **************************************************
  // Buffer entries and array ports.
  // **************************************************

  typedef struct packed {
    logic        present;
    logic [29:0] tag;  // Word address of the stored instruction word.
    logic [31:0] data;
  } buf_entry_t;

  typedef struct packed {
    logic                 wen;
    logic [max_depth-1:0] waddr;
    buf_entry_t           entry;
  } buf_wr_t;

  typedef struct packed {
    logic [max_depth-1:0] addr1;
    logic [max_depth-1:0] addr2;
  } buf_rd_addr_t;

  typedef struct packed {
    buf_entry_t entry1;
    buf_entry_t entry2;
  } buf_rd_data_t;

  typedef union packed {
    logic [31:0] full;
    struct packed {
      logic [15:0] hi;
      logic [15:0] lo;
    } half;
  } instr_word_u;

endpackage

//--- fetch_buffer/fetch_buffer_data.sv
`timescale 1ns/1ps

module fetch_buffer_data #(
  parameter int buffer_depth = 3
) (
  input  logic                    clock,
  input  fetch_pkg::buf_wr_t      wr,
  input  fetch_pkg::buf_rd_addr_t rd_addr,
  output fetch_pkg::buf_rd_data_t rd_data
);
  import fetch_pkg::*;

  localparam int entries = 2 ** buffer_depth;

  buf_entry_t entry_array [entries] = '{default: '0};

  // Word at the request address and the word after it.
  assign rd_data.entry1 = entry_array[rd_addr.addr1[buffer_depth-1:0]];
  assign rd_data.entry2 = entry_array[rd_addr.addr2[buffer_depth-1:0]];

  always_ff @(posedge clock) begin
    if (wr.wen) begin
      entry_array[wr.waddr[buffer_depth-1:0]] <= wr.entry;
    end
  end

endmodule

//--- logic/instr_align.sv
`timescale 1ns/1ps

module instr_align (
  input  logic [31:0]             req_addr,
  input  fetch_pkg::buf_rd_data_t rd_data,
  input  fetch_pkg::buf_wr_t      wr,
  output logic [31:0]             rdata,
  output logic                    ready,
  output logic [1:0]              step,
  output logic                    miss1,
  output logic                    miss2
);
  import fetch_pkg::*;

  logic [29:0] tag1;
  logic [29:0] tag2;
  buf_entry_t  entry1;
  buf_entry_t  entry2;
  logic        hit1;
  logic        hit2;
  instr_word_u word1;
  instr_word_u word2;
  instr_word_u instr;
  logic        compressed;

  assign tag1 = req_addr[31:2];
  assign tag2 = tag1 + 30'd1;

  // A word landing in the array this cycle is used directly.
  always_comb begin
    entry1 = rd_data.entry1;
    entry2 = rd_data.entry2;
    if (wr.wen && wr.entry.tag == tag1) begin
      entry1 = wr.entry;
    end
    if (wr.wen && wr.entry.tag == tag2) begin
      entry2 = wr.entry;
    end
  end

  assign hit1 = entry1.present && entry1.tag == tag1;
  assign hit2 = entry2.present && entry2.tag == tag2;

  assign word1.full = entry1.data;
  assign word2.full = entry2.data;

  always_comb begin
    instr.full = '0;
    ready = 1'b0;
    miss1 = 1'b0;
    miss2 = 1'b0;
    if (!hit1) begin
      miss1 = 1'b1;
    end else if (!req_addr[1]) begin
      instr.half.lo = word1.half.lo;
      instr.half.hi = word1.half.hi;
      ready = 1'b1;
    end else begin
      instr.half.lo = word1.half.hi;
      if (instr.half.lo[1:0] != 2'b11) begin
        ready = 1'b1;
      end else if (hit2) begin
        instr.half.hi = word2.half.lo;  // Instruction straddles two words.
        ready = 1'b1;
      end else begin
        miss2 = 1'b1;
      end
    end
  end

  assign compressed = instr.half.lo[1:0] != 2'b11;

  // Upper half is cleared for a 16-bit instruction.
  assign rdata = compressed ? {16'h0000, instr.half.lo} : instr.full;

  always_comb begin
    if (!ready) begin
      step = 2'd0;
    end else if (compressed) begin
      step = 2'd1;
    end else begin
      step = 2'd2;
    end
  end

endmodule

//--- fetch_buffer/fetch_buffer_ctrl.sv
`timescale 1ns/1ps

module fetch_buffer_ctrl #(
  parameter int buffer_depth = 3
) (
  input  logic                    clock,
  input  logic                    reset,
  input  fetch_pkg::mem_req_t     fetch_req,
  output fetch_pkg::mem_rsp_t     fetch_rsp,
  output fetch_pkg::mem_req_t     imem_req,
  input  fetch_pkg::mem_rsp_t     imem_rsp,
  output fetch_pkg::buf_wr_t      wr,
  output fetch_pkg::buf_rd_addr_t rd_addr,
  input  logic [31:0]             align_rdata,
  input  logic                    align_ready,
  input  logic [1:0]              align_step,
  input  logic                    miss1,
  input  logic                    miss2
);
  import fetch_pkg::*;

  // Halfwords the stream may run ahead of the core.
  localparam logic [buffer_depth:0] max_credit =
    (buffer_depth + 1)'(2 ** (buffer_depth + 1) - 4);

  typedef struct packed {
    logic [31:0]             addr;    // Next word requested from imem.
    logic                    valid;
    logic [buffer_depth:0]   credit;  // Halfwords fetched but not yet consumed.
    logic                    fence;   // Sweep or its closing imem wait is active.
    logic                    swept;
    logic [buffer_depth-1:0] wid;
    logic                    fenced;  // Current fence request already swept.
  } state_t;

  localparam state_t state_init = '{
    addr:   '0,
    valid:  1'b1,
    credit: '0,
    fence:  1'b0,
    swept:  1'b0,
    wid:    '0,
    fenced: 1'b0
  };

  state_t r;
  state_t v;

  logic                  accept;
  logic                  start_sweep;
  logic                  fetch_ready;
  logic                  redirect;
  logic [31:0]           req_word;
  logic [31:0]           target;
  logic [buffer_depth:0] step_ext;
  buf_entry_t            fill_entry;

  // **************************************************
  // Handshake decode.
  // **************************************************

  assign accept      = r.valid & imem_rsp.ready;
  assign start_sweep = fetch_req.valid & fetch_req.fence & ~r.fence & ~r.fenced;
  assign fetch_ready = fetch_req.valid & align_ready & ~r.fence & ~start_sweep;
  assign redirect    = fetch_req.valid & (miss1 | miss2) & ~r.fence & ~start_sweep;

  assign req_word = {fetch_req.addr[31:2], 2'b00};
  assign target   = miss1 ? req_word : req_word + 32'd4;  // Second word missing otherwise.
  assign step_ext = (buffer_depth + 1)'(align_step);

  assign fill_entry = '{present: 1'b1, tag: r.addr[31:2], data: imem_rsp.rdata};

  assign fetch_rsp.ready = fetch_ready;
  assign fetch_rsp.rdata = align_rdata;

  always_comb begin
    imem_req       = '0;
    imem_req.valid = r.valid;
    imem_req.fence = r.fence;
    imem_req.instr = 1'b1;
    imem_req.addr  = r.addr;
  end

  // **************************************************
  // Array ports.
  // **************************************************

  always_comb begin
    wr = '0;
    if (r.fence) begin
      if (!r.swept) begin
        wr.wen = 1'b1;
        wr.waddr[buffer_depth-1:0] = r.wid;  // Entry left all zero.
      end
    end else if (accept) begin
      wr.wen = 1'b1;
      wr.waddr[buffer_depth-1:0] = r.addr[buffer_depth+1:2];
      wr.entry = fill_entry;
    end
  end

  always_comb begin
    rd_addr = '0;
    rd_addr.addr1[buffer_depth-1:0] = fetch_req.addr[buffer_depth+1:2];
    rd_addr.addr2[buffer_depth-1:0] = fetch_req.addr[buffer_depth+1:2] + 1'b1;
  end

  // **************************************************
  // Next state.
  // **************************************************

  always_comb begin
    v = r;
    if (r.fence) begin
      v.valid  = 1'b1;  // One imem answer closes the fence.
      v.credit = '0;
      if (!r.swept) begin
        v.wid   = r.wid + 1'b1;
        v.swept = &r.wid;
      end else if (accept) begin
        v.fence  = 1'b0;
        v.swept  = 1'b0;
        v.fenced = 1'b1;
        if (fetch_req.valid) begin
          v.addr = req_word;  // Restart where the core is waiting.
        end
      end
    end else if (start_sweep) begin
      v.fence  = 1'b1;
      v.swept  = 1'b0;
      v.wid    = '0;
      v.credit = '0;
      v.valid  = 1'b1;
    end else begin
      if (accept) begin
        v.credit = r.credit + (buffer_depth + 1)'(2);
        v.addr   = r.addr + 32'd4;
      end
      if (fetch_ready) begin
        v.credit = (v.credit >= step_ext) ? v.credit - step_ext : '0;
        v.fenced = 1'b0;
      end
      // An outstanding imem request keeps its address until it is answered.
      if (redirect && (accept || !r.valid)) begin
        v.addr   = target;
        v.credit = '0;
      end
      v.valid = v.credit < max_credit;
    end
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      r <= state_init;
    end else begin
      r <= v;
    end
  end

endmodule

//--- fetch_buffer/fetch_buffer.sv
`timescale 1ns/1ps

module fetch_buffer #(
  parameter int buffer_depth = 3
) (
  input  logic                clock,
  input  logic                reset,
  input  fetch_pkg::mem_req_t fetch_req,
  output fetch_pkg::mem_rsp_t fetch_rsp,
  output fetch_pkg::mem_req_t imem_req,
  input  fetch_pkg::mem_rsp_t imem_rsp
);
  import fetch_pkg::*;

  buf_wr_t      wr;
  buf_rd_addr_t rd_addr;
  buf_rd_data_t rd_data;
  logic [31:0]  align_rdata;
  logic         align_ready;
  logic [1:0]   align_step;
  logic         miss1;
  logic         miss2;

  fetch_buffer_ctrl #(
    .buffer_depth(buffer_depth)
  ) ctrl0 (
    .clock      (clock),
    .reset      (reset),
    .fetch_req  (fetch_req),
    .fetch_rsp  (fetch_rsp),
    .imem_req   (imem_req),
    .imem_rsp   (imem_rsp),
    .wr         (wr),
    .rd_addr    (rd_addr),
    .align_rdata(align_rdata),
    .align_ready(align_ready),
    .align_step (align_step),
    .miss1      (miss1),
    .miss2      (miss2)
  );

  instr_align align0 (
    .req_addr(fetch_req.addr),
    .rd_data (rd_data),
    .wr      (wr),
    .rdata   (align_rdata),
    .ready   (align_ready),
    .step    (align_step),
    .miss1   (miss1),
    .miss2   (miss2)
  );

  fetch_buffer_data #(
    .buffer_depth(buffer_depth)
  ) data0 (
    .clock  (clock),
    .wr     (wr),
    .rd_addr(rd_addr),
    .rd_data(rd_data)
  );

endmodule

//--- dv/imem_model.sv
`timescale 1ns/1ps

module imem_model (
  input  logic                clock,
  input  logic                reset,
  input  logic [7:0]          gen,
  input  fetch_pkg::mem_req_t req,
  output fetch_pkg::mem_rsp_t rsp,
  input  logic [31:0]         peek_addr,
  output logic [31:0]         peek_word
);
  import fetch_pkg::*;

  localparam logic [31:0] seed = 32'hbc4d_8dd4;

  logic [31:0] lcg_state;
  logic [31:0] lcg_new;
  logic [1:0]  latency;  // Cycles the current request waits before ready.
  logic [1:0]  waited;

  function automatic logic [31:0] lcg_next(input logic [31:0] x);
    return x * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic logic [31:0] word_at(input logic [31:0] addr, input logic [7:0] g);
    logic [31:0] h;
    h = {2'b00, addr[31:2]} * 32'h9e37_79b1 + {24'h000000, g} * 32'h85eb_ca6b;
    if (addr[31:12] == 20'h00000) begin
      h[1:0] = 2'b11;  // Low 4 KB holds only 32-bit instructions.
    end else begin
      h[1]  = 1'b1;  // Each half is compressed or not on bit 0 alone.
      h[17] = 1'b1;
    end
    return h;
  endfunction

  assign lcg_new   = lcg_next(lcg_state);
  assign rsp.ready = req.valid && waited == latency;
  assign rsp.rdata = word_at(req.addr, gen);
  assign peek_word = word_at(peek_addr, gen);

  always_ff @(posedge clock) begin
    if (!reset) begin
      lcg_state <= seed;
      latency   <= seed[17:16];
      waited    <= 2'd0;
    end else if (req.valid) begin
      if (rsp.ready) begin
        lcg_state <= lcg_new;
        latency   <= lcg_new[17:16];  // Next request waits 0 to 3 cycles.
        waited    <= 2'd0;
      end else begin
        waited <= waited + 2'd1;
      end
    end
  end

endmodule

//--- dv/fetch_buffer_props.sv
`timescale 1ns/1ps

module fetch_buffer_props #(
  parameter int buffer_depth = 3
) (
  input logic                clock,
  input logic                reset,
  input fetch_pkg::mem_req_t fetch_req,
  input fetch_pkg::mem_rsp_t fetch_rsp,
  input fetch_pkg::mem_req_t imem_req,
  input fetch_pkg::mem_rsp_t imem_rsp
);

  logic                  fence_held;  // Fence request seen on the previous edge.
  logic                  fence_start;
  logic [buffer_depth:0] sweep_left;

  assign fence_start = fetch_req.valid && fetch_req.fence && !fence_held;

  always_ff @(posedge clock) begin
    if (!reset) begin
      fence_held <= 1'b0;
      sweep_left <= '0;
    end else begin
      fence_held <= fetch_req.valid && fetch_req.fence;
      if (fence_start) begin
        sweep_left <= (buffer_depth + 1)'(2 ** buffer_depth);  // One cycle per entry.
      end else if (sweep_left != '0) begin
        sweep_left <= sweep_left - 1'b1;
      end
    end
  end

  // A new fence request is held off for the whole sweep of the array.
  no_ready_in_fence: assert property (
    @(posedge clock) disable iff (!reset)
    (fence_start || sweep_left != '0) |-> !fetch_rsp.ready
  ) else $error("Fetch ready was high during a fence sweep.");

  word_aligned_addr: assert property (
    @(posedge clock) disable iff (!reset)
    imem_req.valid |-> imem_req.addr[1:0] == 2'b00
  ) else $error("Imem address is not word aligned.");

  stable_while_stalled: assert property (
    @(posedge clock) disable iff (!reset)
    imem_req.valid && !imem_rsp.ready |=> imem_req.valid && $stable(imem_req.addr)
  ) else $error("Imem request changed while the memory stalled it.");

endmodule

bind fetch_buffer fetch_buffer_props #(
  .buffer_depth(buffer_depth)
) props0 (
  .clock    (clock),
  .reset    (reset),
  .fetch_req(fetch_req),
  .fetch_rsp(fetch_rsp),
  .imem_req (imem_req),
  .imem_rsp (imem_rsp)
);

//--- dv/fetch_buffer_tb.sv
`timescale 1ns/1ps

module fetch_buffer_tb;
  import fetch_pkg::*;

  localparam int buffer_depth = 3;
  localparam int seq_len      = 24;
  localparam int mixed_len    = 40;
  localparam int jump_len     = 4;
  localparam int fence_len    = 16;
  localparam int idle_cycles  = 30;
  localparam int fetch_total  = seq_len + 1 + mixed_len + 4 * jump_len + 5 + fence_len;
  // A fetch waits for at most an outstanding answer and two more words.
  localparam int cycle_limit  = fetch_total * 16 + idle_cycles + 2 ** buffer_depth + 50;

  logic        clock = 1'b0;
  logic        reset;
  mem_req_t    fetch_req;
  mem_rsp_t    fetch_rsp;
  mem_req_t    imem_req;
  mem_rsp_t    imem_rsp;
  logic [7:0]  gen;
  logic [31:0] peek_addr;
  logic [31:0] peek_word;
  int          cycle_count = 0;
  int          check_count = 0;
  int          error_count = 0;
  int          compressed_count = 0;
  int          straddle_count = 0;
  logic [31:0] jump_targets [4] = '{32'h0004_0000, 32'h0012_3456, 32'h00ab_cdea, 32'h0000_2002};

  always #50 clock = ~clock;

  fetch_buffer #(
    .buffer_depth(buffer_depth)
  ) dut0 (
    .clock    (clock),
    .reset    (reset),
    .fetch_req(fetch_req),
    .fetch_rsp(fetch_rsp),
    .imem_req (imem_req),
    .imem_rsp (imem_rsp)
  );

  imem_model imem0 (
    .clock    (clock),
    .reset    (reset),
    .gen      (gen),
    .req      (imem_req),
    .rsp      (imem_rsp),
    .peek_addr(peek_addr),
    .peek_word(peek_word)
  );

  always @(posedge clock) begin
    cycle_count++;
    if (cycle_count > cycle_limit) begin
      $display("Run stopped after %0d cycles before the tests finished.", cycle_count);
      $display("TEST FAIL");
      $finish;
    end
  end

  // **************************************************
  // Expected values and the core-side handshake.
  // **************************************************

  task automatic peek(input logic [31:0] addr, output logic [31:0] word);
    peek_addr = addr;
    #1;
    word = peek_word;
  endtask

  // Builds the instruction at addr from memory words by the halfword rule.
  task automatic expected_instr(input logic [31:0] addr, output logic [31:0] instr,
                                output logic [1:0] size);
    logic [31:0] w1;
    logic [31:0] w2;
    logic [15:0] first;
    logic [15:0] second;
    peek({addr[31:2], 2'b00}, w1);
    peek({addr[31:2], 2'b00} + 32'd4, w2);
    first  = addr[1] ? w1[31:16] : w1[15:0];
    second = addr[1] ? w2[15:0] : w1[31:16];
    if (first[1:0] != 2'b11) begin
      instr = {16'h0000, first};
      size  = 2'd1;
    end else begin
      instr = {second, first};
      size  = 2'd2;
    end
  endtask

  task automatic fetch(input logic [31:0] addr, input logic fence, output int waited,
                       output logic [1:0] size, output logic redirected);
    logic [31:0] expected;
    logic [31:0] got;
    logic        done;
    expected_instr(addr, expected, size);
    @(posedge clock);
    #1;
    fetch_req       = '0;
    fetch_req.valid = 1'b1;
    fetch_req.fence = fence;
    fetch_req.instr = 1'b1;
    fetch_req.addr  = addr;
    waited     = 0;
    redirected = 1'b0;
    done       = 1'b0;
    while (!done) begin
      @(negedge clock);
      if (imem_req.valid && imem_req.addr == {addr[31:2], 2'b00}) begin
        redirected = 1'b1;
      end
      if (fetch_rsp.ready) begin
        done = 1'b1;
      end else begin
        waited++;
      end
    end
    got = fetch_rsp.rdata;
    check_count++;
    assert (got == expected) else begin
      error_count++;
      $display("** Error: fetch_rsp.rdata at %h = %h, expected %h", addr, got, expected);
    end
  endtask

  task automatic idle(input int cycles);
    @(posedge clock);
    #1;
    fetch_req = '0;
    repeat (cycles) @(posedge clock);
  endtask

  task automatic run_sequence(input logic [31:0] start, input int count,
                              output logic [31:0] next);
    logic [31:0] addr;
    int          waited;
    logic [1:0]  size;
    logic        redirected;
    addr = start;
    for (int i = 0; i < count; i++) begin
      fetch(addr, 1'b0, waited, size, redirected);
      if (size == 2'd1) begin
        compressed_count++;
      end else if (addr[1]) begin
        straddle_count++;
      end
      addr = addr + (size == 2'd1 ? 32'd2 : 32'd4);
    end
    next = addr;
  endtask

  // **************************************************
  // Directed tests.
  // **************************************************

  task automatic check_reset_state();
    @(negedge clock);
    check_count += 4;
    assert (!fetch_rsp.ready) else begin
      error_count++;
      $display("** Error: fetch_rsp.ready = %h, expected 0", fetch_rsp.ready);
    end
    assert (imem_req.valid) else begin
      error_count++;
      $display("** Error: imem_req.valid = %h, expected 1", imem_req.valid);
    end
    assert (imem_req.addr == 32'h0000_0000) else begin
      error_count++;
      $display("** Error: imem_req.addr = %h, expected 00000000", imem_req.addr);
    end
    assert (!imem_req.fence) else begin
      error_count++;
      $display("** Error: imem_req.fence = %h, expected 0", imem_req.fence);
    end
  endtask

  task automatic test_sequential();
    logic [31:0] next;
    int          waited;
    logic [1:0]  size;
    logic        redirected;
    run_sequence(32'h0000_0000, seq_len, next);
    idle(idle_cycles);  // Lets the prefetch stream run ahead.
    fetch(next, 1'b0, waited, size, redirected);
    check_count++;
    assert (waited == 0) else begin
      error_count++;
      $display("Fetch at %h missed although prefetch had time to fill the buffer.", next);
    end
  endtask

  task automatic test_compressed();
    logic [31:0] next;
    run_sequence(32'h0000_1000, mixed_len, next);
    check_count += 2;
    assert (compressed_count > 0) else begin
      error_count++;
      $display("Mixed contents gave no compressed instruction to check.");
    end
    assert (straddle_count > 0) else begin
      error_count++;
      $display("Mixed contents gave no instruction straddling two words.");
    end
  endtask

  task automatic test_far_jump();
    logic [31:0] next;
    int          waited;
    logic [1:0]  size;
    logic        redirected;
    foreach (jump_targets[i]) begin
      fetch(jump_targets[i], 1'b0, waited, size, redirected);
      check_count += 2;
      assert (waited > 0) else begin
        error_count++;
        $display("Jump to %h returned at once instead of missing.", jump_targets[i]);
      end
      assert (redirected) else begin
        error_count++;
        $display("Imem address never moved to the word of jump target %h.", jump_targets[i]);
      end
      next = jump_targets[i] + (size == 2'd1 ? 32'd2 : 32'd4);
      run_sequence(next, jump_len - 1, next);
    end
  endtask

  task automatic test_fence();
    logic [31:0] next;
    int          waited;
    logic [1:0]  size;
    logic        redirected;
    run_sequence(32'h0000_0040, 4, next);  // Leaves old contents in the buffer.
    gen = gen + 8'd1;
    fetch(32'h0000_0040, 1'b1, waited, size, redirected);
    check_count++;
    assert (waited > 2 ** buffer_depth) else begin
      error_count++;
      $display("Fence request returned after %0d cycles, before the sweep ended.", waited);
    end
    next = 32'h0000_0040 + (size == 2'd1 ? 32'd2 : 32'd4);
    run_sequence(next, fence_len, next);
  endtask

  initial begin
    reset     = 1'b0;
    fetch_req = '0;
    gen       = 8'd0;
    peek_addr = '0;
    repeat (2) @(posedge clock);
    #1;
    reset = 1'b1;
    check_reset_state();
    test_sequential();
    test_compressed();
    test_far_jump();
    test_fence();
    idle(2);
    $display("Checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

//--- list.f
common/fetch_pkg.sv
fetch_buffer/fetch_buffer_data.sv
logic/instr_align.sv
fetch_buffer/fetch_buffer_ctrl.sv
fetch_buffer/fetch_buffer.sv
dv/imem_model.sv
dv/fetch_buffer_props.sv
dv/fetch_buffer_tb.sv

//--- run.sh
#!/bin/sh
# Builds the testbench with Verilator and runs it from the project root.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
  --top-module fetch_buffer_tb \
  -Mdir obj_dir \
  -f list.f
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status."
  exit $status
fi

output=$(./obj_dir/Vfetch_buffer_tb)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status."
  exit $status
fi

if printf '%s\n' "$output" | grep -qx "TEST PASS"; then
  exit 0
fi
echo "Pass message not found in the simulation output."
exit 1
